//--- i2c_multi_target.f
+incdir+design
design/i2c_pkg.sv
design/i2c_line_conditioner.sv
design/i2c_target_engine.sv
design/i2c_bus_merge.sv
design/i2c_multi_target.sv
bench/i2c_multi_target_asserts.sv
bench/i2c_multi_target_tb.sv

//--- bench/i2c_multi_target_tb.sv
// I2C multi-target testbench: clock, reset, bit-banged master, stimulus table, checks, summary
`default_nettype none
`include "i2c_params.svh"

module i2c_multi_target_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NROWS = 10;
  localparam int LIMIT = NROWS * (4 + 2) * 9 * 100 + 2000;

  typedef struct packed {
    logic [6:0]      addr;
    logic            rw;
    logic [2:0]      nbytes;
    logic [3:0][7:0] data;
    logic            load;
    logic [7:0]      load_byte;
    logic            rs;       // repeated start mid-write
    logic [6:0]      rs_addr;
    logic            exp_ack;
  } row_t;

  logic clk = 1'b0;
  logic reset = 1'b1;
  logic m_sda = 1'b1;
  logic m_scl = 1'b1;
  logic sda_bus;
  logic sda_oen;
  i2c_pkg::tx_load_t                 tx_load = '0;
  i2c_pkg::rx_byte_t                 rx;
  i2c_pkg::cmd_t                     cmd;
  logic [`I2C_NUM_TARGETS-1:0]       tx_busy;

  row_t       rows [NROWS];
  logic [9:0] rx_seen [$];
  logic [2:0] cmd_seen [$];
  int         errors = 0;
  int         failed_rows = 0;
  int         cycles = 0;

  assign sda_bus = m_sda & sda_oen;  // open-drain bus

  i2c_multi_target dut (
    .clk       (clk),
    .reset     (reset),
    .sda_i     (sda_bus),
    .scl_i     (m_scl),
    .tx_load_i (tx_load),
    .sda_oen_o (sda_oen),
    .rx_o      (rx),
    .cmd_o     (cmd),
    .tx_busy_o (tx_busy)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT) begin
      $display("SOME TESTS FAILED");
      $display("timeout: run did not finish within %0d cycles", LIMIT);
      $finish;
    end
  end

  always @(negedge clk) begin
    if (!reset && rx.valid) rx_seen.push_back({rx.slot, rx.data});
    if (!reset && cmd.valid) cmd_seen.push_back({cmd.slot, cmd.rw_n});
  end

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    errors++;
    $display("ERROR %s expected %h got %h", name, exp, got);
  endtask

  task automatic drive_bit(input logic b);
    wait_cycles(30);  // past the target hold
    m_sda = b;
    wait_cycles(20);
    m_scl = 1'b1;
    wait_cycles(50);
    m_scl = 1'b0;
  endtask

  task automatic read_bit(output logic b);
    wait_cycles(30);
    m_sda = 1'b1;
    wait_cycles(20);
    m_scl = 1'b1;
    wait_cycles(25);
    b = sda_bus;
    wait_cycles(25);
    m_scl = 1'b0;
  endtask

  task automatic bus_start(input logic repeated);
    if (repeated) begin
      wait_cycles(30);
      m_sda = 1'b1;
      wait_cycles(20);
      m_scl = 1'b1;
    end
    wait_cycles(25);
    m_sda = 1'b0;  // falls while scl high
    wait_cycles(25);
    m_scl = 1'b0;
  endtask

  task automatic bus_stop();
    wait_cycles(30);
    m_sda = 1'b0;
    wait_cycles(20);
    m_scl = 1'b1;
    wait_cycles(25);
    m_sda = 1'b1;
    wait_cycles(25);
  endtask

  task automatic write_byte(input logic [7:0] b, output logic ack);
    for (int i = 7; i >= 0; i--) drive_bit(b[i]);
    read_bit(ack);
  endtask

  task automatic read_byte(output logic [7:0] b);
    for (int i = 7; i >= 0; i--) read_bit(b[i]);
  endtask

  function automatic row_t make_row(input logic [6:0] addr, input logic rw, input int n,
                                    input logic load, input logic [7:0] lb,
                                    input logic rs, input logic [6:0] rs_addr,
                                    input logic exp_ack);
    row_t t;
    t.addr = addr;
    t.rw = rw;
    t.nbytes = 3'(n);
    for (int i = 0; i < 4; i++) t.data[i] = 8'($urandom);
    t.load = load;
    t.load_byte = lb;
    t.rs = rs;
    t.rs_addr = rs_addr;
    t.exp_ack = exp_ack;
    return t;
  endfunction

  task automatic run_row(input int r);
    row_t         t;
    logic         ack;
    logic [7:0]   got;
    logic [7:0]   exp_byte;
    logic [1:0]   slot;
    logic [9:0]   exp_rx [$];
    logic [2:0]   exp_cmd [$];
    logic [`I2C_NUM_TARGETS-1:0] busy_exp;
    int           errs0;
    int           first;
    t = rows[r];
    errs0 = errors;
    first = 0;
    slot = 2'(t.addr - `I2C_BASE_ADDR);
    rx_seen.delete();
    cmd_seen.delete();
    if (t.load) begin
      tx_load = '{valid: 1'b1, slot: slot, data: t.load_byte};
      @(negedge clk);
      tx_load = '0;
      busy_exp = '0;
      busy_exp[slot] = 1'b1;  // only the loaded slot pending
      if (tx_busy !== busy_exp) report_mismatch("tx_busy_o", busy_exp, tx_busy);
    end
    bus_start(1'b0);
    write_byte({t.addr, t.rw}, ack);
    if (ack !== !t.exp_ack) report_mismatch("addr_ack", !t.exp_ack, ack);
    if (t.exp_ack) exp_cmd.push_back({slot, t.rw});
    if (t.rs) begin
      write_byte(t.data[0], ack);
      if (ack !== 1'b0) report_mismatch("data_ack", 0, ack);
      exp_rx.push_back({slot, t.data[0]});
      for (int i = 7; i >= 5; i--) drive_bit(t.data[1][i]);  // partial byte
      bus_start(1'b1);
      slot = 2'(t.rs_addr - `I2C_BASE_ADDR);
      write_byte({t.rs_addr, 1'b0}, ack);
      if (ack !== 1'b0) report_mismatch("rs_addr_ack", 0, ack);
      exp_cmd.push_back({slot, 1'b0});
      first = 2;
    end
    if (t.exp_ack && !t.rw) begin
      for (int i = first; i < t.nbytes; i++) begin
        write_byte(t.data[i], ack);
        if (ack !== 1'b0) report_mismatch("data_ack", 0, ack);
        exp_rx.push_back({slot, t.data[i]});
      end
    end else if (t.exp_ack) begin
      exp_byte = t.load ? t.load_byte : 8'hA3;
      for (int i = 0; i < t.nbytes; i++) begin
        read_byte(got);
        if (got !== exp_byte) report_mismatch("read_data", exp_byte, got);
        drive_bit(i == t.nbytes - 1);  // nack on the last byte
      end
      wait_cycles(40);
      if (sda_oen !== 1'b1) report_mismatch("sda_oen_o", 1, sda_oen);
      if (tx_busy !== '0) report_mismatch("tx_busy_o", 0, tx_busy);
    end
    bus_stop();
    wait_cycles(50);
    if (sda_oen !== 1'b1) report_mismatch("sda_oen_o", 1, sda_oen);
    if (rx_seen.size() != exp_rx.size()) begin
      report_mismatch("rx_o count", exp_rx.size(), rx_seen.size());
    end else begin
      foreach (exp_rx[i]) begin
        if (rx_seen[i] !== exp_rx[i]) report_mismatch("rx_o", exp_rx[i], rx_seen[i]);
      end
    end
    if (cmd_seen.size() != exp_cmd.size()) begin
      report_mismatch("cmd_o count", exp_cmd.size(), cmd_seen.size());
    end else begin
      foreach (exp_cmd[i]) begin
        if (cmd_seen[i] !== exp_cmd[i]) report_mismatch("cmd_o", exp_cmd[i], cmd_seen[i]);
      end
    end
    if (errors != errs0) failed_rows++;
    $display("row %0d addr %h rw %0d: %s", r, t.addr, t.rw, (errors == errs0) ? "pass" : "fail");
  endtask

  initial begin
    void'($urandom(32'h74d32171));
    rows[0] = make_row(7'h2A, 1'b0, 2, 1'b0, 8'h00, 1'b0, 7'h00, 1'b1);
    rows[1] = make_row(7'h2B, 1'b0, 3, 1'b0, 8'h00, 1'b0, 7'h00, 1'b1);
    rows[2] = make_row(7'h2C, 1'b0, 1, 1'b0, 8'h00, 1'b0, 7'h00, 1'b1);
    rows[3] = make_row(7'h2D, 1'b0, 2, 1'b0, 8'h00, 1'b0, 7'h00, 1'b1);
    rows[4] = make_row(7'h30, 1'b0, 1, 1'b0, 8'h00, 1'b0, 7'h00, 1'b0);
    rows[5] = make_row(7'h29, 1'b0, 1, 1'b0, 8'h00, 1'b0, 7'h00, 1'b0);
    rows[6] = make_row(7'h2C, 1'b1, 3, 1'b1, 8'h5A, 1'b0, 7'h00, 1'b1);
    rows[7] = make_row(7'h2D, 1'b1, 1, 1'b0, 8'h00, 1'b0, 7'h00, 1'b1);  // never loaded
    rows[8] = make_row(7'h2A, 1'b1, 1, 1'b1, 8'hC3, 1'b0, 7'h00, 1'b1);
    rows[9] = make_row(7'h2B, 1'b0, 4, 1'b0, 8'h00, 1'b1, 7'h2D, 1'b1);
    wait_cycles(10);
    reset = 1'b0;
    wait_cycles(20);
    for (int r = 0; r < NROWS; r++) run_row(r);
    $display("%0d rows run, %0d failed, %0d errors", NROWS, failed_rows, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/i2c_multi_target_asserts.sv
// I2C subsystem assertions: single pulling engine, one-cycle strobes, SDA released when idle
`default_nettype none
`include "i2c_params.svh"

module i2c_multi_target_asserts (
  input logic                        clk,
  input logic                        reset,
  input logic                        busy_i,
  input logic [`I2C_NUM_TARGETS-1:0] eng_oen_i,
  input logic                        rx_valid_i,
  input logic                        cmd_valid_i,
  input logic                        sda_oen_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // only the addressed engine may pull SDA
  one_driver: assert property (@(posedge clk) disable iff (reset)
    $countones(~eng_oen_i) <= 1)
    else $error("more than one engine drives SDA");

  rx_pulse: assert property (@(posedge clk) disable iff (reset)
    rx_valid_i |=> !rx_valid_i)
    else $error("rx valid longer than one cycle");

  cmd_pulse: assert property (@(posedge clk) disable iff (reset)
    cmd_valid_i |=> !cmd_valid_i)
    else $error("cmd valid longer than one cycle");

  // engine release and merge register lag the stop by two cycles
  idle_release: assert property (@(posedge clk) disable iff (reset)
    (!busy_i && !$past(busy_i) && !$past(busy_i, 2)) |-> sda_oen_i)
    else $error("SDA driven while bus idle");

endmodule

bind i2c_multi_target i2c_multi_target_asserts u_asserts (
  .clk         (clk),
  .reset       (reset),
  .busy_i      (events.busy),
  .eng_oen_i   (sda_oen_w),
  .rx_valid_i  (rx_o.valid),
  .cmd_valid_i (cmd_o.valid),
  .sda_oen_i   (sda_oen_o)
);

`default_nettype wire

//--- design/i2c_multi_target.sv
// I2C multi-address target top: line conditioner, engine array, output merge
`default_nettype none
`include "i2c_params.svh"

module i2c_multi_target (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        sda_i,
  input  logic                        scl_i,
  input  i2c_pkg::tx_load_t           tx_load_i,
  output logic                        sda_oen_o,
  output i2c_pkg::rx_byte_t           rx_o,
  output i2c_pkg::cmd_t               cmd_o,
  output logic [`I2C_NUM_TARGETS-1:0] tx_busy_o
);

  i2c_pkg::bus_events_t              events;
  logic [`I2C_NUM_TARGETS-1:0]       sda_oen_w;
  i2c_pkg::rx_byte_t                 rx_w [`I2C_NUM_TARGETS];
  i2c_pkg::cmd_t                     cmd_w [`I2C_NUM_TARGETS];

  i2c_line_conditioner u_cond (
    .clk      (clk),
    .reset    (reset),
    .sda_i    (sda_i),
    .scl_i    (scl_i),
    .events_o (events)
  );

  // one engine per consecutive address
  for (genvar g = 0; g < `I2C_NUM_TARGETS; g++) begin : g_tgt
    i2c_target_engine #(.SLOT(g)) u_engine (
      .clk       (clk),
      .reset     (reset),
      .events_i  (events),
      .tx_load_i (tx_load_i),
      .sda_oen_o (sda_oen_w[g]),
      .rx_o      (rx_w[g]),
      .cmd_o     (cmd_w[g]),
      .tx_busy_o (tx_busy_o[g])
    );
  end

  i2c_bus_merge u_merge (
    .clk       (clk),
    .reset     (reset),
    .sda_oen_i (sda_oen_w),
    .rx_i      (rx_w),
    .cmd_i     (cmd_w),
    .sda_oen_o (sda_oen_o),
    .rx_o      (rx_o),
    .cmd_o     (cmd_o)
  );

endmodule

`default_nettype wire

//--- design/i2c_bus_merge.sv
// I2C bus merge: wired-AND of SDA enables, lowest-slot select of rx and cmd strobes
`default_nettype none
`include "i2c_params.svh"

module i2c_bus_merge (
  input  logic                          clk,
  input  logic                          reset,
  input  logic [`I2C_NUM_TARGETS-1:0]   sda_oen_i,
  input  i2c_pkg::rx_byte_t             rx_i [`I2C_NUM_TARGETS],
  input  i2c_pkg::cmd_t                 cmd_i [`I2C_NUM_TARGETS],
  output logic                          sda_oen_o,
  output i2c_pkg::rx_byte_t             rx_o,
  output i2c_pkg::cmd_t                 cmd_o
);

  i2c_pkg::rx_byte_t rx_sel;
  i2c_pkg::cmd_t     cmd_sel;

  // walk down so the lowest valid slot is the last one written
  always_comb begin
    rx_sel  = '0;
    cmd_sel = '0;
    for (int i = `I2C_NUM_TARGETS - 1; i >= 0; i--) begin
      if (rx_i[i].valid) begin
        rx_sel = rx_i[i];
      end
      if (cmd_i[i].valid) begin
        cmd_sel = cmd_i[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      sda_oen_o   <= 1'b1;  // released
      rx_o.valid  <= 1'b0;
      cmd_o.valid <= 1'b0;
    end else begin
      sda_oen_o <= &sda_oen_i;  // any engine pulling wins
      rx_o      <= rx_sel;
      cmd_o     <= cmd_sel;
    end
  end

endmodule

`default_nettype wire

//--- design/i2c_target_engine.sv
// I2C target engine: address match, byte FSM, bit-phase FSM with SDA hold timer
`default_nettype none
`include "i2c_params.svh"

module i2c_target_engine #(
  parameter int SLOT = 0
) (
  input  logic                 clk,
  input  logic                 reset,
  input  i2c_pkg::bus_events_t events_i,
  input  i2c_pkg::tx_load_t    tx_load_i,
  output logic                 sda_oen_o,
  output i2c_pkg::rx_byte_t    rx_o,
  output i2c_pkg::cmd_t        cmd_o,
  output logic                 tx_busy_o
);

  localparam i2c_pkg::addr_t     MY_ADDR = i2c_pkg::addr_t'(`I2C_BASE_ADDR + SLOT);
  localparam i2c_pkg::slot_t     MY_SLOT = i2c_pkg::slot_t'(SLOT);
  localparam i2c_pkg::hold_cnt_t HOLD    = i2c_pkg::hold_cnt_t'(`I2C_HOLD_CYCLES);

  i2c_pkg::tgt_state_e state;
  i2c_pkg::bit_phase_e phase;
  i2c_pkg::hold_cnt_t  hold_cnt;
  i2c_pkg::byte_t      tx_data;
  i2c_pkg::byte_t      rx_shift;

  logic [2:0] bit_idx;
  logic       rw_n;
  logic       addr_acked;  // cmd already reported this transfer
  logic       bit_req;
  logic       bit_dir_out;
  logic       bit_out;
  logic       bit_last;    // release SDA after this bit
  logic       bit_done;
  logic       bit_in;
  logic       rx_valid;
  logic       cmd_valid;
  logic       tx_busy;
  logic       bus_reset;
  logic       load_hit;
  logic       launch_last;

  assign bus_reset   = events_i.start | events_i.stop;
  assign load_hit    = tx_load_i.valid && (tx_load_i.slot == MY_SLOT);
  assign launch_last = events_i.busy && !bus_reset &&
                       (state == i2c_pkg::st_word_send) && (bit_idx == 3'd7);

  // transmit byte and its busy flag
  always_ff @(posedge clk) begin
    if (reset) begin
      tx_data <= `I2C_TX_RESET_BYTE;
      tx_busy <= 1'b0;
    end else begin
      if (launch_last) begin
        tx_busy <= 1'b0;
      end
      if (load_hit) begin  // newest load wins
        tx_data <= tx_load_i.data;
        tx_busy <= 1'b1;
      end
    end
  end

  // byte level
  always_ff @(posedge clk) begin
    bit_req   <= 1'b0;
    rx_valid  <= 1'b0;
    cmd_valid <= 1'b0;
    if (reset) begin
      state      <= i2c_pkg::st_idle;
      bit_idx    <= 3'd0;
      addr_acked <= 1'b0;
    end else if (bus_reset) begin
      state      <= i2c_pkg::st_ctl_read;
      bit_idx    <= 3'd0;
      addr_acked <= 1'b0;
    end else if (events_i.busy) begin
      case (state)
        i2c_pkg::st_idle: begin
        end
        i2c_pkg::st_ctl_read: begin
          bit_req     <= 1'b1;
          bit_dir_out <= 1'b0;
          state       <= i2c_pkg::st_ctl_proc;
        end
        i2c_pkg::st_ctl_proc: begin
          if (bit_done) begin
            rx_shift <= {rx_shift[6:0], bit_in};
            if (bit_idx == 3'd7) begin
              rw_n <= bit_in;
              if (rx_shift[6:0] == MY_ADDR) begin
                state <= i2c_pkg::st_ack_send;
              end else begin
                state <= i2c_pkg::st_idle;  // not ours, stay off the bus
              end
            end else begin
              bit_idx <= bit_idx + 3'd1;
              state   <= i2c_pkg::st_ctl_read;
            end
          end
        end
        i2c_pkg::st_ack_send: begin
          bit_req     <= 1'b1;
          bit_dir_out <= 1'b1;
          bit_out     <= 1'b0;
          bit_last    <= ~rw_n;  // a read keeps SDA until the first data bit
          state       <= i2c_pkg::st_ack_wait;
        end
        i2c_pkg::st_ack_wait: begin
          if (bit_done) begin
            bit_idx <= 3'd0;
            if (!addr_acked) begin
              cmd_valid  <= 1'b1;
              addr_acked <= 1'b1;
            end
            state <= rw_n ? i2c_pkg::st_word_send : i2c_pkg::st_word_read;
          end
        end
        i2c_pkg::st_word_read: begin
          bit_req     <= 1'b1;
          bit_dir_out <= 1'b0;
          state       <= i2c_pkg::st_word_proc;
        end
        i2c_pkg::st_word_proc: begin
          if (bit_done) begin
            rx_shift <= {rx_shift[6:0], bit_in};
            if (bit_idx == 3'd7) begin
              rx_valid <= 1'b1;
              state    <= i2c_pkg::st_ack_send;
            end else begin
              bit_idx <= bit_idx + 3'd1;
              state   <= i2c_pkg::st_word_read;
            end
          end
        end
        i2c_pkg::st_word_send: begin
          bit_req     <= 1'b1;
          bit_dir_out <= 1'b1;
          bit_out     <= tx_data[3'd7 - bit_idx];  // msb first
          bit_last    <= (bit_idx == 3'd7);
          state       <= i2c_pkg::st_word_wait;
        end
        i2c_pkg::st_word_wait: begin
          if (bit_done) begin
            if (bit_idx == 3'd7) begin
              state <= i2c_pkg::st_ackm_read;
            end else begin
              bit_idx <= bit_idx + 3'd1;
              state   <= i2c_pkg::st_word_send;
            end
          end
        end
        i2c_pkg::st_ackm_read: begin
          bit_req     <= 1'b1;
          bit_dir_out <= 1'b0;
          state       <= i2c_pkg::st_ackm_proc;
        end
        i2c_pkg::st_ackm_proc: begin
          if (bit_done) begin
            if (bit_in) begin
              state <= i2c_pkg::st_idle;  // nack ends the read
            end else begin
              bit_idx <= 3'd0;
              state   <= i2c_pkg::st_word_send;
            end
          end
        end
        default: begin
          state <= i2c_pkg::st_idle;
        end
      endcase
    end
  end

  // bit level, shared by both directions
  always_ff @(posedge clk) begin
    bit_done <= 1'b0;
    if (reset || bus_reset) begin
      phase     <= i2c_pkg::ph_idle;
      hold_cnt  <= '0;
      sda_oen_o <= 1'b1;
    end else begin
      case (phase)
        i2c_pkg::ph_idle: begin
          if (bit_req) begin
            if (bit_dir_out) begin
              sda_oen_o <= bit_out;  // launch
              phase     <= i2c_pkg::ph_edge;
            end else begin
              phase <= i2c_pkg::ph_find;
            end
          end
        end
        i2c_pkg::ph_find: begin
          if (events_i.scl_rise) begin
            bit_in <= events_i.sda;
            phase  <= i2c_pkg::ph_edge;
          end
        end
        i2c_pkg::ph_edge: begin
          if (events_i.scl_fall) begin
            hold_cnt <= HOLD;
            phase    <= i2c_pkg::ph_wait;
          end
        end
        i2c_pkg::ph_wait: begin
          if (hold_cnt != '0) begin
            hold_cnt <= hold_cnt - 16'd1;
          end else begin
            bit_done <= 1'b1;
            if (bit_dir_out && bit_last) begin
              sda_oen_o <= 1'b1;
            end
            phase <= i2c_pkg::ph_idle;
          end
        end
        default: begin
          phase <= i2c_pkg::ph_idle;
        end
      endcase
    end
  end

  assign rx_o      = '{valid: rx_valid, slot: MY_SLOT, data: rx_shift};
  assign cmd_o     = '{valid: cmd_valid, slot: MY_SLOT, rw_n: rw_n};
  assign tx_busy_o = tx_busy;

endmodule

`default_nettype wire

//--- design/i2c_line_conditioner.sv
// I2C line conditioner: SDA/SCL debounce, edge, start, stop and bus-busy events
`default_nettype none
`include "i2c_params.svh"

module i2c_line_conditioner (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 sda_i,
  input  logic                 scl_i,
  output i2c_pkg::bus_events_t events_o
);

  localparam int DB_W = $clog2(`I2C_DEBOUNCE + 1);

  logic [1:0]      raw;       // {scl, sda}
  logic [1:0]      filt;
  logic [1:0]      filt_prev;
  logic [DB_W-1:0] lock_cnt [2];
  logic            start_c;
  logic            stop_c;

  assign raw = {scl_i, sda_i};

  // per line: follow the pin, then ignore it for a while
  always_ff @(posedge clk) begin
    if (reset) begin
      filt <= 2'b11;  // idle bus is high
      for (int i = 0; i < 2; i++) begin
        lock_cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (lock_cnt[i] != '0) begin
          lock_cnt[i] <= lock_cnt[i] - 1'b1;
        end else if (raw[i] != filt[i]) begin
          filt[i]     <= raw[i];
          lock_cnt[i] <= DB_W'(`I2C_DEBOUNCE);
        end
      end
    end
  end

  // SDA moving while SCL stays high
  assign start_c = ~filt[0] & filt_prev[0] & filt[1] & filt_prev[1];
  assign stop_c  = filt[0] & ~filt_prev[0] & filt[1] & filt_prev[1];

  always_ff @(posedge clk) begin
    if (reset) begin
      filt_prev         <= 2'b11;
      events_o.sda      <= 1'b1;
      events_o.scl_rise <= 1'b0;
      events_o.scl_fall <= 1'b0;
      events_o.start    <= 1'b0;
      events_o.stop     <= 1'b0;
      events_o.busy     <= 1'b0;
    end else begin
      filt_prev         <= filt;
      events_o.sda      <= filt[0];
      events_o.scl_rise <= filt[1] & ~filt_prev[1];
      events_o.scl_fall <= ~filt[1] & filt_prev[1];
      events_o.start    <= start_c;
      events_o.stop     <= stop_c;
      if (start_c) begin
        events_o.busy <= 1'b1;
      end else if (stop_c) begin
        events_o.busy <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/i2c_pkg.sv
// I2C subsystem types: widths, event and strobe structs, engine state enums
`default_nettype none
`include "i2c_params.svh"

package i2c_pkg;

  typedef logic [7:0] byte_t;
  typedef logic [6:0] addr_t;
  typedef logic [$clog2(`I2C_NUM_TARGETS)-1:0] slot_t;
  typedef logic [15:0] hold_cnt_t;

  // filtered bus view shared by all engines
  typedef struct packed {
    logic sda;      // filtered level
    logic scl_rise;
    logic scl_fall;
    logic start;
    logic stop;
    logic busy;     // between start and stop
  } bus_events_t;

  typedef struct packed {
    logic  valid;
    slot_t slot;
    byte_t data;
  } tx_load_t;

  typedef struct packed {
    logic  valid;
    slot_t slot;
    byte_t data;
  } rx_byte_t;

  typedef struct packed {
    logic  valid;
    slot_t slot;
    logic  rw_n;  // 1 = master reads
  } cmd_t;

  typedef enum logic [3:0] {
    st_idle, st_ctl_read, st_ctl_proc, st_ack_send, st_ack_wait, st_word_send,
    st_word_wait, st_word_read, st_word_proc, st_ackm_read, st_ackm_proc
  } tgt_state_e;

  typedef enum logic [1:0] {ph_idle, ph_edge, ph_wait, ph_find} bit_phase_e;

endpackage

`default_nettype wire

//--- design/i2c_params.svh
// I2C subsystem macros: target count, addressing, bus timing, debounce, reset transmit byte
`ifndef I2C_PARAMS_SVH
`define I2C_PARAMS_SVH

// number of target engines behind the pins
`define I2C_NUM_TARGETS 4

// slot 0 answers here, slot n on base + n
`define I2C_BASE_ADDR 7'h2A

// clock and bus rates
`define I2C_CLK_HZ 10_000_000
`define I2C_SCL_HZ 100_000
`define I2C_BIT_CYCLES (`I2C_CLK_HZ / `I2C_SCL_HZ)

// SDA hold after SCL falls, a fifth of a bit
`define I2C_HOLD_CYCLES (`I2C_BIT_CYCLES / 5)

// lock-out after an accepted line change
`define I2C_DEBOUNCE 7

// read data before any load
`define I2C_TX_RESET_BYTE 8'hA3

`endif
